// ==== list.f ====
verilog/edge_detect_pkg.sv
verilog/line_buffer.sv
verilog/line_writer.sv
verilog/sobel_window.sv
verilog/edge_detect.sv
tb/edge_detect_sva.sv
tb/edge_checker.sv
tb/tb_edge_detect.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_edge_detect
FILELIST := list.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := test passed
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_edge_detect.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_edge_detect;

  import edge_detect_pkg::*;

  localparam int SEED = 57;
  localparam int N_TESTS = 6;
  localparam int FRAME_PIX = IMG_COLS * IMG_ROWS;
  localparam int FULL_STROBES = (IMG_ROWS - 2) * (IMG_COLS - 2);

  // pattern kinds
  localparam int K_FLAT = 0;
  localparam int K_VSTEP = 1;
  localparam int K_HSTEP = 2;
  localparam int K_RANDOM = 3;

  // enable modes
  localparam int EN_OFF = 0;
  localparam int EN_ON = 1;
  localparam int EN_TOGGLE = 2;

  // enable low over rows 3 and 4 of the first frame
  localparam int DROP_FROM = 3 * IMG_COLS;
  localparam int DROP_TO = 5 * IMG_COLS;
  // last strobes of row 2 are still in flight at the drop and get lost
  localparam int TOGGLE_STROBES = (IMG_COLS - 2 - (EDGE_LATENCY + 1)) + FULL_STROBES;

  // stimulus table
  string test_name    [N_TESTS] = '{"flat", "vertical step", "horizontal step",
                                    "random x2", "bypass", "enable toggle"};
  int    test_mode    [N_TESTS] = '{EN_ON, EN_ON, EN_ON, EN_ON, EN_OFF, EN_TOGGLE};
  int    test_kind    [N_TESTS] = '{K_FLAT, K_VSTEP, K_HSTEP, K_RANDOM, K_RANDOM, K_RANDOM};
  int    test_frames  [N_TESTS] = '{1, 1, 1, 2, 1, 2};
  int    test_strobes [N_TESTS] = '{FULL_STROBES, FULL_STROBES, FULL_STROBES,
                                    2 * FULL_STROBES, 0, TOGGLE_STROBES};
  bit    test_bypass  [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

  logic             clk;
  logic             rst;
  logic             edge_en;
  logic             frame_start;
  logic [PIX_W-1:0] in_r;
  logic [PIX_W-1:0] in_g;
  logic [PIX_W-1:0] in_b;
  logic [PIX_W-1:0] out_r;
  logic [PIX_W-1:0] out_g;
  logic [PIX_W-1:0] out_b;
  logic             edge_valid;

  // checker counters
  int strobes;
  int errors;
  int bypass_cycles;
  int pending;

  int fail_count = 0;

  edge_detect i_dut (
    .clk         (clk),
    .rst         (rst),
    .edge_en     (edge_en),
    .frame_start (frame_start),
    .in_r        (in_r),
    .in_g        (in_g),
    .in_b        (in_b),
    .out_r       (out_r),
    .out_g       (out_g),
    .out_b       (out_b),
    .edge_valid  (edge_valid)
  );

  edge_checker i_checker (
    .clk           (clk),
    .rst           (rst),
    .edge_en       (edge_en),
    .frame_start   (frame_start),
    .in_r          (in_r),
    .in_g          (in_g),
    .in_b          (in_b),
    .out_r         (out_r),
    .out_g         (out_g),
    .out_b         (out_b),
    .edge_valid    (edge_valid),
    .strobes       (strobes),
    .errors        (errors),
    .bypass_cycles (bypass_cycles),
    .pending       (pending)
  );

  bind edge_detect edge_detect_sva i_sva (
    .clk        (clk),
    .rst        (rst),
    .edge_en    (edge_en),
    .edge_valid (edge_valid),
    .out_r      (out_r),
    .out_g      (out_g),
    .out_b      (out_b)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic enable_for(input int mode, input int frame, input int idx);
    if (mode == EN_OFF) begin
      return 1'b0;
    end
    if (mode == EN_TOGGLE && frame == 0 && idx >= DROP_FROM && idx < DROP_TO) begin
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic set_pixel(input int kind, input int row, input int col);
    int v;
    case (kind)
      K_FLAT: begin
        in_r = PIX_W'(40);
        in_g = PIX_W'(100);
        in_b = PIX_W'(200);
      end
      K_VSTEP, K_HSTEP: begin
        if (kind == K_VSTEP) begin
          v = (col < IMG_COLS / 2) ? 0 : 255;
        end else begin
          v = (row < IMG_ROWS / 2) ? 20 : 200;
        end
        in_r = PIX_W'(v);
        in_g = PIX_W'(v);
        in_b = PIX_W'(v);
      end
      default: begin
        in_r = PIX_W'($urandom);
        in_g = PIX_W'($urandom);
        in_b = PIX_W'($urandom);
      end
    endcase
  endtask

  task automatic run_test(input int t);
    int s0;
    int e0;
    int b0;
    int cyc;
    int limit;
    int got;
    int errs;
    s0 = strobes;
    e0 = errors;
    b0 = bypass_cycles;
    cyc = 0;
    errs = 0;
    limit = test_frames[t] * FRAME_PIX + 20;
    for (int f = 0; f < test_frames[t]; f++) begin
      for (int p = 0; p < FRAME_PIX; p++) begin
        @(posedge clk);
        #2;
        cyc++;
        frame_start = (p == 0);
        edge_en = enable_for(test_mode[t], f, p);
        set_pixel(test_kind[t], p / IMG_COLS, p % IMG_COLS);
      end
    end
    @(posedge clk);
    #2;
    cyc++;
    frame_start = 1'b0;
    edge_en = 1'b1;
    in_r = '0;
    in_g = '0;
    in_b = '0;
    // drain the last strobes of the frame
    while (pending != 0 && cyc < limit) begin
      @(posedge clk);
      cyc++;
    end
    if (pending != 0) begin
      $display("timeout: %0d expected strobes of %s never arrived", pending, test_name[t]);
      errs++;
    end
    // room for a stray strobe to show up
    repeat (EDGE_LATENCY + 1) @(posedge clk);
    got = strobes - s0;
    errs += errors - e0;
    if (got != test_strobes[t]) begin
      $display("%s gave %0d strobes where %0d were expected", test_name[t], got,
               test_strobes[t]);
      errs++;
    end
    if ((bypass_cycles != b0) != test_bypass[t]) begin
      $display("%s did not use the bypass as planned", test_name[t]);
      errs++;
    end
    $display("%s: strobes %0d, errors %0d, %s", test_name[t], got, errs,
             (errs == 0) ? "ok" : "bad");
    fail_count += errs;
  endtask

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    edge_en = 1'b1;
    frame_start = 1'b0;
    in_r = '0;
    in_g = '0;
    in_b = '0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("tests %0d, strobes %0d, errors %0d", N_TESTS, strobes, fail_count);
    if (fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/edge_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module edge_checker (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             edge_en,
  input  logic                             frame_start,
  input  logic [edge_detect_pkg::PIX_W-1:0] in_r,
  input  logic [edge_detect_pkg::PIX_W-1:0] in_g,
  input  logic [edge_detect_pkg::PIX_W-1:0] in_b,
  input  logic [edge_detect_pkg::PIX_W-1:0] out_r,
  input  logic [edge_detect_pkg::PIX_W-1:0] out_g,
  input  logic [edge_detect_pkg::PIX_W-1:0] out_b,
  input  logic                             edge_valid,
  output int                               strobes,
  output int                               errors,
  output int                               bypass_cycles,
  output int                               pending
);

  import edge_detect_pkg::*;

  // greys of the current frame
  int img [IMG_ROWS][IMG_COLS];

  // due step, magnitude and centre of each expected strobe
  int due_q [$];
  int val_q [$];
  int row_q [$];
  int col_q [$];

  int n_strobes = 0;
  int n_errors = 0;
  int n_bypass = 0;
  int n_pending = 0;
  int step = 0;
  bit running = 1'b0;
  int cur_row = 0;
  int cur_col = 0;

  assign strobes       = n_strobes;
  assign errors        = n_errors;
  assign bypass_cycles = n_bypass;
  assign pending       = n_pending;

  function automatic int kernel_sum(input int a, input int m, input int b);
    return a + 2 * m + b;
  endfunction

  // sobel magnitude for centre (r,c)
  function automatic int sobel_at(input int r, input int c);
    int gx;
    int gy;
    int m;
    gx = kernel_sum(img[r-1][c+1], img[r][c+1], img[r+1][c+1])
       - kernel_sum(img[r-1][c-1], img[r][c-1], img[r+1][c-1]);
    gy = kernel_sum(img[r+1][c-1], img[r+1][c], img[r+1][c+1])
       - kernel_sum(img[r-1][c-1], img[r-1][c], img[r-1][c+1]);
    m = ((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy);
    return (m > MAG_MAX) ? MAG_MAX : m;
  endfunction

  task automatic check_byte(input string name, input logic [PIX_W-1:0] expected,
                            input logic [PIX_W-1:0] actual, input string where);
    if (actual !== expected) begin
      $display("mismatch %s expected %h got %h %s", name, expected, actual, where);
      n_errors++;
    end
  endtask

  task automatic flush_pending();
    due_q.delete();
    val_q.delete();
    row_q.delete();
    col_q.delete();
  endtask

  task automatic pop_pending();
    void'(due_q.pop_front());
    void'(val_q.pop_front());
    void'(row_q.pop_front());
    void'(col_q.pop_front());
  endtask

  task automatic check_strobe();
    string where;
    if (edge_valid === 1'b1) begin
      n_strobes++;
      if (due_q.size() == 0 || due_q[0] != step) begin
        $display("unexpected edge_valid strobe with no interior centre due");
        n_errors++;
      end else begin
        where = $sformatf("at centre (%0d,%0d)", row_q[0], col_q[0]);
        check_byte("out_r", PIX_W'(val_q[0]), out_r, where);
        check_byte("out_g", PIX_W'(val_q[0]), out_g, where);
        check_byte("out_b", PIX_W'(val_q[0]), out_b, where);
        pop_pending();
      end
    end else if (due_q.size() != 0 && due_q[0] == step) begin
      $display("no edge_valid strobe for centre (%0d,%0d)", row_q[0], col_q[0]);
      n_errors++;
      pop_pending();
    end
  endtask

  // raster position and expected result of the pixel seen now
  task automatic take_pixel();
    if (frame_start) begin
      running = 1'b1;
      cur_row = 0;
      cur_col = 0;
    end
    if (running) begin
      img[cur_row][cur_col] = (int'(in_r) + 2 * int'(in_g) + int'(in_b)) / 4;
      if (cur_row >= 2 && cur_col >= 2) begin
        // pixel is sampled one edge after it is seen here
        due_q.push_back(step + EDGE_LATENCY + 1);
        val_q.push_back(sobel_at(cur_row - 1, cur_col - 1));
        row_q.push_back(cur_row - 1);
        col_q.push_back(cur_col - 1);
      end
      if (cur_col == IMG_COLS - 1) begin
        cur_col = 0;
        if (cur_row == IMG_ROWS - 1) begin
          running = 1'b0;
        end else begin
          cur_row++;
        end
      end else begin
        cur_col++;
      end
    end
  endtask

  // inputs and outputs are both settled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      flush_pending();
      running = 1'b0;
    end else begin
      step++;
      if (!edge_en) begin
        // in-flight strobes are masked by the bypass
        flush_pending();
        running = 1'b0;
        n_bypass++;
        if (edge_valid !== 1'b0) begin
          $display("edge_valid strobe while edge detection is off");
          n_errors++;
        end
        check_byte("out_r", in_r, out_r, "in bypass");
        check_byte("out_g", in_g, out_g, "in bypass");
        check_byte("out_b", in_b, out_b, "in bypass");
      end else begin
        check_strobe();
        take_pixel();
      end
    end
    n_pending = due_q.size();
  end

endmodule

`default_nettype wire

// ==== tb/edge_detect_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module edge_detect_sva (
  input logic                             clk,
  input logic                             rst,
  input logic                             edge_en,
  input logic                             edge_valid,
  input logic [edge_detect_pkg::PIX_W-1:0] out_r,
  input logic [edge_detect_pkg::PIX_W-1:0] out_g,
  input logic [edge_detect_pkg::PIX_W-1:0] out_b
);

  // bypass selected, so no strobe
  a_off_no_strobe: assert property (@(posedge clk) disable iff (rst) !edge_en |-> !edge_valid)
    else $error("edge_valid high while edge_en is low");

  // reset clears the strobe
  a_rst_clears: assert property (@(posedge clk) rst |=> !edge_valid)
    else $error("edge_valid high in the cycle after reset");

  a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(edge_valid))
    else $error("edge_valid unknown after reset");

  // outputs carry data on a strobe or in bypass
  a_out_known: assert property (@(posedge clk) disable iff (rst)
    (edge_valid || !edge_en) |-> !$isunknown({out_r, out_g, out_b}))
    else $error("out_r/g/b unknown while carrying data");

endmodule

`default_nettype wire

// ==== verilog/edge_detect.sv ====
`timescale 1ns/100ps
`default_nettype none

module edge_detect (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             edge_en,
  input  logic                             frame_start,
  input  logic [edge_detect_pkg::PIX_W-1:0] in_r,
  input  logic [edge_detect_pkg::PIX_W-1:0] in_g,
  input  logic [edge_detect_pkg::PIX_W-1:0] in_b,
  output logic [edge_detect_pkg::PIX_W-1:0] out_r,
  output logic [edge_detect_pkg::PIX_W-1:0] out_g,
  output logic [edge_detect_pkg::PIX_W-1:0] out_b,
  output logic                             edge_valid
);

  import edge_detect_pkg::*;

  // writer to buffers
  logic [NUM_LINES-1:0] wr_sel;
  logic [COL_W-1:0]     col;
  logic [PIX_W-1:0]     grey;

  // writer and buffers to window
  logic [PIX_W-1:0]                  grey_d;
  logic [LINE_W-1:0]                 line_base;
  logic                              win_ok;
  logic [NUM_LINES-1:0][PIX_W-1:0]   line_data;

  // window result
  logic [PIX_W-1:0] mag;
  logic             sobel_valid;

  line_writer i_line_writer (
    .clk         (clk),
    .rst         (rst),
    .edge_en     (edge_en),
    .frame_start (frame_start),
    .in_r        (in_r),
    .in_g        (in_g),
    .in_b        (in_b),
    .wr_sel      (wr_sel),
    .col         (col),
    .grey        (grey),
    .grey_d      (grey_d),
    .line_base   (line_base),
    .win_ok      (win_ok)
  );

  // rotating row storage
  for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
    line_buffer i_line_buffer (
      .clk     (clk),
      .wr_en   (wr_sel[i]),
      .col     (col),
      .wr_data (grey),
      .rd_data (line_data[i])
    );
  end

  sobel_window i_sobel_window (
    .clk        (clk),
    .rst        (rst),
    .line_data  (line_data),
    .grey_d     (grey_d),
    .line_base  (line_base),
    .win_ok     (win_ok),
    .mag        (mag),
    .edge_valid (sobel_valid)
  );

  // raw pixel and no strobes while detection is off
  assign out_r      = edge_en ? mag : in_r;
  assign out_g      = edge_en ? mag : in_g;
  assign out_b      = edge_en ? mag : in_b;
  assign edge_valid = edge_en & sobel_valid;

endmodule

`default_nettype wire

// ==== verilog/sobel_window.sv ====
`timescale 1ns/100ps
`default_nettype none

module sobel_window (
  input  logic                                                          clk,
  input  logic                                                          rst,
  input  logic [edge_detect_pkg::NUM_LINES-1:0][edge_detect_pkg::PIX_W-1:0] line_data,
  input  logic [edge_detect_pkg::PIX_W-1:0]                              grey_d,
  input  logic [edge_detect_pkg::LINE_W-1:0]                             line_base,
  input  logic                                                          win_ok,
  output logic [edge_detect_pkg::PIX_W-1:0]                              mag,
  output logic                                                          edge_valid
);

  import edge_detect_pkg::*;

  // row selection from the rotating buffers
  logic [LINE_W-1:0] mid_line;
  logic [PIX_W-1:0]  top_px;
  logic [PIX_W-1:0]  mid_px;

  // rows top to bottom, columns left to right
  logic [PIX_W-1:0] win [3][3];
  logic             win_ok_d;

  // gradient arithmetic
  logic [SUM_W-1:0] sum_l;
  logic [SUM_W-1:0] sum_r;
  logic [SUM_W-1:0] sum_t;
  logic [SUM_W-1:0] sum_b;
  logic [SUM_W:0]   gx;
  logic [SUM_W:0]   gy;
  logic [SUM_W-1:0] abs_x;
  logic [SUM_W-1:0] abs_y;
  logic [MAG_W-1:0] total;
  logic [PIX_W-1:0] mag_next;

  // kernel weights 1, 2, 1
  function automatic logic [SUM_W-1:0] wsum(
    input logic [PIX_W-1:0] a,
    input logic [PIX_W-1:0] m,
    input logic [PIX_W-1:0] b
  );
    return SUM_W'(a) + SUM_W'({m, 1'b0}) + SUM_W'(b);
  endfunction

  // oldest row at line_base, the next one after it
  assign mid_line = (line_base == LINE_W'(NUM_LINES - 1)) ? '0 : line_base + 1'b1;
  assign top_px   = line_data[line_base];
  assign mid_px   = line_data[mid_line];

  // new column enters on the right
  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      win[i][0] <= win[i][1];
      win[i][1] <= win[i][2];
    end
    win[0][2] <= top_px;
    win[1][2] <= mid_px;
    win[2][2] <= grey_d;
  end

  assign sum_l = wsum(win[0][0], win[1][0], win[2][0]);
  assign sum_r = wsum(win[0][2], win[1][2], win[2][2]);
  assign sum_t = wsum(win[0][0], win[0][1], win[0][2]);
  assign sum_b = wsum(win[2][0], win[2][1], win[2][2]);

  // two's complement differences, sign in the top bit
  assign gx = {1'b0, sum_r} - {1'b0, sum_l};
  assign gy = {1'b0, sum_b} - {1'b0, sum_t};

  assign abs_x = gx[SUM_W] ? SUM_W'(~gx + 1'b1) : gx[SUM_W-1:0];
  assign abs_y = gy[SUM_W] ? SUM_W'(~gy + 1'b1) : gy[SUM_W-1:0];

  assign total    = {1'b0, abs_x} + {1'b0, abs_y};
  assign mag_next = (total > MAG_W'(MAG_MAX)) ? PIX_W'(MAG_MAX) : total[PIX_W-1:0];

  always_ff @(posedge clk) begin
    mag <= mag_next;
  end

  // interior flag follows the window, then the magnitude
  always_ff @(posedge clk) begin
    if (rst) begin
      win_ok_d   <= 1'b0;
      edge_valid <= 1'b0;
    end else begin
      win_ok_d   <= win_ok;
      edge_valid <= win_ok_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/line_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_writer (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 edge_en,
  input  logic                                 frame_start,
  input  logic [edge_detect_pkg::PIX_W-1:0]     in_r,
  input  logic [edge_detect_pkg::PIX_W-1:0]     in_g,
  input  logic [edge_detect_pkg::PIX_W-1:0]     in_b,
  output logic [edge_detect_pkg::NUM_LINES-1:0] wr_sel,
  output logic [edge_detect_pkg::COL_W-1:0]     col,
  output logic [edge_detect_pkg::PIX_W-1:0]     grey,
  output logic [edge_detect_pkg::PIX_W-1:0]     grey_d,
  output logic [edge_detect_pkg::LINE_W-1:0]    line_base,
  output logic                                 win_ok
);

  import edge_detect_pkg::*;

  // position expected for the next pixel of the frame
  logic              running;
  logic [COL_W-1:0]  nxt_col;
  logic [ROW_W-1:0]  nxt_row;
  logic [LINE_W-1:0] nxt_line;

  // position of the pixel on the inputs now
  logic              take;
  logic [COL_W-1:0]  pix_col;
  logic [ROW_W-1:0]  pix_row;
  logic [LINE_W-1:0] pix_line;
  logic [LINE_W-1:0] line_next;
  logic              row_end;
  logic              frame_end;
  logic [PIX_W+1:0]  grey_sum;

  // side info of the first stage
  logic [LINE_W-1:0] base_s1;
  logic              win_ok_s1;

  // frame_start forces the origin, even mid-frame
  assign take     = edge_en & (frame_start | running);
  assign pix_col  = frame_start ? '0 : nxt_col;
  assign pix_row  = frame_start ? '0 : nxt_row;
  assign pix_line = frame_start ? '0 : nxt_line;

  // the line after the write line holds the oldest row
  assign line_next = (pix_line == LINE_W'(NUM_LINES - 1)) ? '0 : pix_line + 1'b1;

  assign row_end   = (pix_col == COL_W'(IMG_COLS - 1));
  assign frame_end = row_end & (pix_row == ROW_W'(IMG_ROWS - 1));

  // r + 2g + b, divided by four below
  assign grey_sum = {2'b00, in_r} + {1'b0, in_g, 1'b0} + {2'b00, in_b};

  // raster counting and line rotation
  always_ff @(posedge clk) begin
    if (rst) begin
      running  <= 1'b0;
      nxt_col  <= '0;
      nxt_row  <= '0;
      nxt_line <= '0;
    end else if (!edge_en) begin
      running <= 1'b0;
    end else if (take) begin
      running <= !frame_end;
      if (row_end) begin
        nxt_col  <= '0;
        nxt_row  <= pix_row + 1'b1;
        nxt_line <= line_next;
      end else begin
        nxt_col  <= pix_col + 1'b1;
        nxt_row  <= pix_row;
        nxt_line <= pix_line;
      end
    end
  end

  // write strobe and interior flag
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_sel    <= '0;
      win_ok_s1 <= 1'b0;
      win_ok    <= 1'b0;
    end else begin
      wr_sel    <= take ? (NUM_LINES'(1) << pix_line) : '0;
      win_ok_s1 <= take & (pix_row >= ROW_W'(2)) & (pix_col >= COL_W'(2));
      win_ok    <= win_ok_s1 & edge_en;
    end
  end

  // stage 1 feeds the buffers, stage 2 lines up with their reads
  always_ff @(posedge clk) begin
    col       <= pix_col;
    grey      <= grey_sum[PIX_W+1:2];
    base_s1   <= line_next;
    grey_d    <= grey;
    line_base <= base_s1;
  end

endmodule

`default_nettype wire

// ==== verilog/line_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_buffer (
  input  logic                             clk,
  input  logic                             wr_en,
  input  logic [edge_detect_pkg::COL_W-1:0] col,
  input  logic [edge_detect_pkg::PIX_W-1:0] wr_data,
  output logic [edge_detect_pkg::PIX_W-1:0] rd_data
);

  import edge_detect_pkg::*;

  // one grey row
  logic [PIX_W-1:0] mem [IMG_COLS];

  // read returns the word from before this cycle's write
  always_ff @(posedge clk) begin
    rd_data <= mem[col];
    if (wr_en) begin
      mem[col] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/edge_detect_pkg.sv ====
`default_nettype none

package edge_detect_pkg;

  // width of one colour channel and of one grey pixel
  localparam int PIX_W = 8;

  // frame geometry kept small for simulation
  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 8;

  // raster index widths
  localparam int COL_W = $clog2(IMG_COLS);
  localparam int ROW_W = $clog2(IMG_ROWS);

  // two stored rows plus the one being written
  localparam int NUM_LINES = 3;
  localparam int LINE_W = $clog2(NUM_LINES + 1);

  // magnitude clips at the largest grey value
  localparam int MAG_MAX = 255;

  // input pixel that completes a window to its registered magnitude
  localparam int EDGE_LATENCY = 3;

  // a + 2m + b over one kernel column or row
  localparam int SUM_W = PIX_W + 2;

  // |gx| + |gy| before saturation
  localparam int MAG_W = SUM_W + 1;

endpackage

`default_nettype wire
